// ==== common/bmu_settings.svh ====
`ifndef BMU_SETTINGS_SVH
`define BMU_SETTINGS_SVH

// Width of one operand or result word
// The decoder and the reference model only know the RV32 encodings, so keep this at 32
`define BMU_XLEN 32

// Number of result words the output buffer can hold while the consumer stalls
// Two entries let the execute stage keep streaming at one result per cycle
`define BMU_RESULT_DEPTH 2

`endif

// ==== common/bmu_pkg.sv ====
`include "bmu_settings.svh"

package bmu_pkg;

    // One operand or result word
    typedef logic [`BMU_XLEN-1:0] data_t;

    // Instruction words are 32 bits wide for every RV32 encoding
    typedef logic [31:0] instr_t;

    // Bit index for the single-bit operations and the rotate amount
    typedef logic [$clog2(`BMU_XLEN)-1:0] shamt_t;

    // Zero and population counts, one extra bit so a full word count fits
    typedef logic [$clog2(`BMU_XLEN):0] count_t;

    // Operation class, picks the registered result group at the stage output
    typedef enum logic [2:0] {
        SHADD,
        LOGIC,
        COUNT,
        COMPARE,
        EXTEND,
        ROTATE,
        BYTEOP,
        SINGLEBIT
    } bmu_class_e;

    // Operation within a class
    typedef enum logic [4:0] {
        SH1ADD, SH2ADD, SH3ADD,
        ANDN, ORN, XNOR,
        CLZ, CTZ, CPOP,
        MAX, MAXU, MIN, MINU,
        SEXTB, SEXTH, ZEXTH,
        ROL, ROR,
        ORCB, REV8,
        BCLR, BEXT, BINV, BSET
    } bmu_opcode_e;

endpackage

// ==== common/bmu_op_if.sv ====
`timescale 1ns/1ps

// One decoded operation on its way from the decoder to the execute stage
// An item moves on a cycle where valid and ready are both high
interface bmu_op_if import bmu_pkg::*; ();

    logic        valid;
    logic        ready;
    bmu_class_e  op_class;
    bmu_opcode_e opcode;
    logic        illegal;
    data_t       operand_a;
    data_t       operand_b;

    // Decoder side drives the operation and watches the stage ready
    modport decode (
        output valid, op_class, opcode, illegal, operand_a, operand_b,
        input  ready
    );

    // Execute side consumes the operation and signals when it can take one
    modport execute (
        input  valid, op_class, opcode, illegal, operand_a, operand_b,
        output ready
    );

endinterface

// ==== bit_manip/count_zeros.sv ====
`timescale 1ns/1ps

`include "bmu_settings.svh"

module count_zeros import bmu_pkg::*; (
    input  data_t  operand_i,
    output count_t count_o,
    output logic   all_zero_o
);

    // Walk up from bit 0 so the highest set bit has the last word
    // With no bit set the count stays at the full word width
    always_comb begin
        count_o = count_t'(`BMU_XLEN);
        for (int i = 0; i < `BMU_XLEN; i++) begin
            if (operand_i[i]) begin
                count_o = count_t'(`BMU_XLEN - 1 - i);
            end
        end
    end

    assign all_zero_o = ~|operand_i;

endmodule

// ==== bit_manip/bit_manip_unit.sv ====
`timescale 1ns/1ps

`include "bmu_settings.svh"

module bit_manip_unit import bmu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    bmu_op_if.execute op,
    output logic      res_valid_o,
    input  logic      res_ready_i,
    output data_t     res_data_o,
    output logic      res_illegal_o
);

    logic   accept;
    logic   valid_q;
    data_t  a;
    data_t  b;
    shamt_t amt;

    assign a   = op.operand_a;
    assign b   = op.operand_b;
    // Rotates and single-bit ops only look at the low bits of B
    assign amt = b[$clog2(`BMU_XLEN)-1:0];

    // The stage takes a new item when empty or when its current one leaves
    assign op.ready = ~valid_q | res_ready_i;
    assign accept   = op.valid & op.ready;

    // ---------------------------------------------------------------------
    // Shift and add
    // ---------------------------------------------------------------------
    data_t shadd_d;

    always_comb begin
        case (op.opcode)
            SH2ADD:  shadd_d = b + (a << 2);
            SH3ADD:  shadd_d = b + (a << 3);
            default: shadd_d = b + (a << 1);
        endcase
    end

    // ---------------------------------------------------------------------
    // Logic with negate
    // ---------------------------------------------------------------------
    data_t logic_d;

    always_comb begin
        case (op.opcode)
            ORN:     logic_d = a | ~b;
            XNOR:    logic_d = ~(a ^ b);
            default: logic_d = a & ~b;
        endcase
    end

    // ---------------------------------------------------------------------
    // Counts
    // ---------------------------------------------------------------------
    data_t  a_rev;
    data_t  cz_operand;
    count_t cz_count;
    count_t pop_count;
    count_t count_d;

    // Trailing zeros are leading zeros of the mirrored word
    always_comb begin
        for (int i = 0; i < `BMU_XLEN; i++) begin
            a_rev[`BMU_XLEN - 1 - i] = a[i];
        end
    end

    assign cz_operand = (op.opcode == CTZ) ? a_rev : a;

    count_zeros u_count_zeros (
        .operand_i  (cz_operand),
        .count_o    (cz_count),
        .all_zero_o ()
    );

    always_comb begin
        pop_count = '0;
        for (int i = 0; i < `BMU_XLEN; i++) begin
            pop_count = pop_count + count_t'(a[i]);
        end
    end

    // Cpop comes from the adder chain, clz and ctz from the zero counter
    assign count_d = (op.opcode == CPOP) ? pop_count : cz_count;

    // ---------------------------------------------------------------------
    // Min and max
    // ---------------------------------------------------------------------
    logic  lt_signed;
    logic  lt_unsigned;
    data_t compare_d;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op.opcode)
            MAX:     compare_d = lt_signed   ? b : a;
            MAXU:    compare_d = lt_unsigned ? b : a;
            MIN:     compare_d = lt_signed   ? a : b;
            default: compare_d = lt_unsigned ? a : b;
        endcase
    end

    // ---------------------------------------------------------------------
    // Extensions
    // ---------------------------------------------------------------------
    data_t extend_d;

    always_comb begin
        case (op.opcode)
            SEXTB:   extend_d = {{(`BMU_XLEN - 8){a[7]}}, a[7:0]};
            SEXTH:   extend_d = {{(`BMU_XLEN - 16){a[15]}}, a[15:0]};
            default: extend_d = {{(`BMU_XLEN - 16){1'b0}}, a[15:0]};
        endcase
    end

    // ---------------------------------------------------------------------
    // Rotates
    // ---------------------------------------------------------------------
    shamt_t amt_inv;
    data_t  rotate_d;

    // Complement amount wraps to zero when amt is zero, which keeps a shift of 0
    assign amt_inv = shamt_t'(~amt + 1'b1);

    always_comb begin
        if (op.opcode == ROL) rotate_d = (a << amt) | (a >> amt_inv);
        else                  rotate_d = (a >> amt) | (a << amt_inv);
    end

    // ---------------------------------------------------------------------
    // Byte operations
    // ---------------------------------------------------------------------
    data_t orcb;
    data_t rev8;
    data_t byteop_d;

    always_comb begin
        for (int i = 0; i < `BMU_XLEN / 8; i++) begin
            orcb[i*8 +: 8]                          = {8{|a[i*8 +: 8]}};
            rev8[(`BMU_XLEN / 8 - 1 - i)*8 +: 8]    = a[i*8 +: 8];
        end
    end

    assign byteop_d = (op.opcode == REV8) ? rev8 : orcb;

    // ---------------------------------------------------------------------
    // Single-bit operations
    // ---------------------------------------------------------------------
    data_t bit_mask;
    data_t singlebit_d;

    assign bit_mask = data_t'(1) << amt;

    always_comb begin
        case (op.opcode)
            BCLR:    singlebit_d = a & ~bit_mask;
            BEXT:    singlebit_d = data_t'(a[amt]);
            BINV:    singlebit_d = a ^ bit_mask;
            default: singlebit_d = a | bit_mask;
        endcase
    end

    // ---------------------------------------------------------------------
    // Stage register and result select
    // ---------------------------------------------------------------------
    data_t      shadd_q, logic_q, compare_q, extend_q, rotate_q, byteop_q, singlebit_q;
    count_t     count_q;
    bmu_class_e class_q;
    logic       illegal_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (op.ready) begin
            valid_q <= op.valid;
        end
    end

    // Every class result is captured, the class decides which one is used
    always_ff @(posedge clk_i) begin
        if (accept) begin
            shadd_q     <= shadd_d;
            logic_q     <= logic_d;
            count_q     <= count_d;
            compare_q   <= compare_d;
            extend_q    <= extend_d;
            rotate_q    <= rotate_d;
            byteop_q    <= byteop_d;
            singlebit_q <= singlebit_d;
            class_q     <= op.op_class;
            illegal_q   <= op.illegal;
        end
    end

    always_comb begin
        case (class_q)
            SHADD:     res_data_o = shadd_q;
            COUNT:     res_data_o = data_t'(count_q);
            COMPARE:   res_data_o = compare_q;
            EXTEND:    res_data_o = extend_q;
            ROTATE:    res_data_o = rotate_q;
            BYTEOP:    res_data_o = byteop_q;
            SINGLEBIT: res_data_o = singlebit_q;
            default:   res_data_o = logic_q;
        endcase
        // An unknown encoding always returns zero
        if (illegal_q) res_data_o = '0;
    end

    assign res_valid_o   = valid_q;
    assign res_illegal_o = illegal_q;

endmodule

// ==== hw/bmu_decoder.sv ====
`timescale 1ns/1ps

module bmu_decoder import bmu_pkg::*; (
    input  instr_t   instr_i,
    input  data_t    operand_a_i,
    input  data_t    operand_b_i,
    input  logic     in_valid_i,
    bmu_op_if.decode op
);

    // Major opcodes of the register-register and register-immediate groups
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    logic [6:0]  opc;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rs2;
    logic        legal;
    bmu_opcode_e dec_op;

    assign opc    = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rs2    = instr_i[24:20];

    // Unmatched words keep ANDN, which lands them in class LOGIC
    always_comb begin
        dec_op = ANDN;
        legal  = 1'b1;
        case (opc)
            OPC_OP: begin
                case ({funct7, funct3})
                    {7'b0010000, 3'b010}: dec_op = SH1ADD;
                    {7'b0010000, 3'b100}: dec_op = SH2ADD;
                    {7'b0010000, 3'b110}: dec_op = SH3ADD;
                    {7'b0100000, 3'b111}: dec_op = ANDN;
                    {7'b0100000, 3'b110}: dec_op = ORN;
                    {7'b0100000, 3'b100}: dec_op = XNOR;
                    {7'b0000101, 3'b110}: dec_op = MAX;
                    {7'b0000101, 3'b111}: dec_op = MAXU;
                    {7'b0000101, 3'b100}: dec_op = MIN;
                    {7'b0000101, 3'b101}: dec_op = MINU;
                    {7'b0110000, 3'b001}: dec_op = ROL;
                    {7'b0110000, 3'b101}: dec_op = ROR;
                    {7'b0100100, 3'b001}: dec_op = BCLR;
                    {7'b0100100, 3'b101}: dec_op = BEXT;
                    {7'b0110100, 3'b001}: dec_op = BINV;
                    {7'b0010100, 3'b001}: dec_op = BSET;
                    // zext.h is the RV32 pack form with rs2 tied to x0
                    {7'b0000100, 3'b100}: begin
                        if (rs2 == 5'b00000) dec_op = ZEXTH;
                        else                 legal  = 1'b0;
                    end
                    default: legal = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // Unary forms, the rs2 field selects the operation
                case ({funct7, funct3})
                    {7'b0110000, 3'b001}: begin
                        case (rs2)
                            5'b00000: dec_op = CLZ;
                            5'b00001: dec_op = CTZ;
                            5'b00010: dec_op = CPOP;
                            5'b00100: dec_op = SEXTB;
                            5'b00101: dec_op = SEXTH;
                            default:  legal  = 1'b0;
                        endcase
                    end
                    {7'b0010100, 3'b101}: begin
                        if (rs2 == 5'b00111) dec_op = ORCB;
                        else                 legal  = 1'b0;
                    end
                    {7'b0110100, 3'b101}: begin
                        if (rs2 == 5'b11000) dec_op = REV8;
                        else                 legal  = 1'b0;
                    end
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

    // Class follows from the opcode alone
    always_comb begin
        case (dec_op)
            SH1ADD, SH2ADD, SH3ADD:   op.op_class = SHADD;
            CLZ, CTZ, CPOP:           op.op_class = COUNT;
            MAX, MAXU, MIN, MINU:     op.op_class = COMPARE;
            SEXTB, SEXTH, ZEXTH:      op.op_class = EXTEND;
            ROL, ROR:                 op.op_class = ROTATE;
            ORCB, REV8:               op.op_class = BYTEOP;
            BCLR, BEXT, BINV, BSET:   op.op_class = SINGLEBIT;
            default:                  op.op_class = LOGIC;
        endcase
    end

    assign op.opcode    = dec_op;
    assign op.illegal   = ~legal;
    assign op.valid     = in_valid_i;
    assign op.operand_a = operand_a_i;
    assign op.operand_b = operand_b_i;

endmodule

// ==== hw/bmu_result_buffer.sv ====
`timescale 1ns/1ps

`include "bmu_settings.svh"

module bmu_result_buffer import bmu_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  wr_valid_i,
    output logic  wr_ready_o,
    input  data_t wr_data_i,
    input  logic  wr_illegal_i,
    output logic  rd_valid_o,
    input  logic  rd_ready_i,
    output data_t rd_data_o,
    output logic  rd_illegal_o
);

    localparam int DEPTH = `BMU_RESULT_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    data_t            data_mem [DEPTH];
    logic             illegal_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // A full buffer refuses writes, so read and write never meet when full
    assign wr_ready_o = (count != CNT_W'(DEPTH));
    assign rd_valid_o = (count != '0);
    assign do_wr      = wr_valid_i & wr_ready_o;
    assign do_rd      = rd_valid_o & rd_ready_i;

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            data_mem[wr_ptr]    <= wr_data_i;
            illegal_mem[wr_ptr] <= wr_illegal_i;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_wr && !do_rd)      count <= count + 1'b1;
            else if (do_rd && !do_wr) count <= count - 1'b1;
        end
    end

    assign rd_data_o    = data_mem[rd_ptr];
    assign rd_illegal_o = illegal_mem[rd_ptr];

endmodule

// ==== hw/bmu_top.sv ====
`timescale 1ns/1ps

module bmu_top import bmu_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   in_valid_i,
    output logic   in_ready_o,
    input  instr_t instr_i,
    input  data_t  operand_a_i,
    input  data_t  operand_b_i,
    output logic   out_valid_o,
    input  logic   out_ready_i,
    output data_t  result_o,
    output logic   illegal_o
);

    bmu_op_if op_if ();

    logic  res_valid;
    logic  res_ready;
    data_t res_data;
    logic  res_illegal;

    // Decode is pure logic, so the input handshake is the stage handshake
    assign in_ready_o = op_if.ready;

    bmu_decoder u_decoder (
        .instr_i     (instr_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .in_valid_i  (in_valid_i),
        .op          (op_if.decode)
    );

    bit_manip_unit u_unit (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .op            (op_if.execute),
        .res_valid_o   (res_valid),
        .res_ready_i   (res_ready),
        .res_data_o    (res_data),
        .res_illegal_o (res_illegal)
    );

    // Two result slots absorb consumer stalls behind the stage
    bmu_result_buffer u_result_buffer (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .wr_valid_i   (res_valid),
        .wr_ready_o   (res_ready),
        .wr_data_i    (res_data),
        .wr_illegal_i (res_illegal),
        .rd_valid_o   (out_valid_o),
        .rd_ready_i   (out_ready_i),
        .rd_data_o    (result_o),
        .rd_illegal_o (illegal_o)
    );

endmodule

// ==== tests/bmu_checker.sv ====
`timescale 1ns/1ps

module bmu_checker import bmu_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   in_valid_i,
    input  logic   in_ready_i,
    input  instr_t instr_i,
    input  data_t  operand_a_i,
    input  data_t  operand_b_i,
    input  logic   out_valid_i,
    input  logic   out_ready_i,
    input  data_t  result_i,
    input  logic   illegal_i,
    input  logic   streaming_i,
    output int     pending_o,
    output int     value_errors_o,
    output int     protocol_errors_o
);

    // Cycles from input handshake to output handshake with no back-pressure
    localparam int STREAM_LATENCY = 2;

    // One entry per accepted operation, oldest first
    data_t       exp_data [$];
    logic        exp_illegal [$];
    instr_t      exp_instr [$];
    int          exp_cycle [$];
    logic        exp_timed [$];

    int          cycle_count;
    logic        seen_input;
    logic [32:0] expected;
    data_t       head_data;
    logic        head_illegal;
    instr_t      head_instr;
    int          head_cycle;
    logic        head_timed;

    initial begin
        cycle_count       = 0;
        seen_input        = 1'b0;
        pending_o         = 0;
        value_errors_o    = 0;
        protocol_errors_o = 0;
    end

    // Rotate one bit at a time, left or right
    function automatic data_t rotate_word(input data_t value, input logic [4:0] amount,
                                          input logic to_left);
        data_t r;
        r = value;
        for (int i = 0; i < amount; i++) begin
            if (to_left) r = {r[30:0], r[31]};
            else         r = {r[0], r[31:1]};
        end
        return r;
    endfunction

    // ISA reference for the Zba/Zbb/Zbs subset, returns {illegal, result}
    function automatic logic [32:0] reference_result(input instr_t instr, input data_t a,
                                                     input data_t b);
        logic [6:0] opcode;
        logic [6:0] funct7;
        logic [2:0] funct3;
        logic [4:0] rs2;
        logic [4:0] amount;
        data_t      r;
        logic       bad;
        int         n;

        opcode = instr[6:0];
        funct7 = instr[31:25];
        funct3 = instr[14:12];
        rs2    = instr[24:20];
        amount = b[4:0];
        r      = '0;
        bad    = 1'b0;
        n      = 0;
        if (opcode == 7'h33) begin
            case ({funct7, funct3})
                {7'h10, 3'd2}: r = b + (a << 1);
                {7'h10, 3'd4}: r = b + (a << 2);
                {7'h10, 3'd6}: r = b + (a << 3);
                {7'h20, 3'd7}: r = a & ~b;
                {7'h20, 3'd6}: r = a | ~b;
                {7'h20, 3'd4}: r = ~(a ^ b);
                {7'h05, 3'd6}: r = (int'(a) > int'(b)) ? a : b;
                {7'h05, 3'd7}: r = (a > b) ? a : b;
                {7'h05, 3'd4}: r = (int'(a) < int'(b)) ? a : b;
                {7'h05, 3'd5}: r = (a < b) ? a : b;
                // zext.h only exists with rs2 = x0
                {7'h04, 3'd4}: begin
                    if (rs2 == 5'd0) r = {16'h0000, a[15:0]};
                    else             bad = 1'b1;
                end
                {7'h30, 3'd1}: r = rotate_word(a, amount, 1'b1);
                {7'h30, 3'd5}: r = rotate_word(a, amount, 1'b0);
                {7'h24, 3'd1}: r = a & ~(32'h1 << amount);
                {7'h24, 3'd5}: r = {31'h0, a[amount]};
                {7'h34, 3'd1}: r = a ^ (32'h1 << amount);
                {7'h14, 3'd1}: r = a | (32'h1 << amount);
                default:       bad = 1'b1;
            endcase
        end else if (opcode == 7'h13) begin
            case ({funct7, funct3, rs2})
                {7'h30, 3'd1, 5'd0}: begin
                    while (n < 32 && !a[31 - n]) n++;
                    r = data_t'(n);
                end
                {7'h30, 3'd1, 5'd1}: begin
                    while (n < 32 && !a[n]) n++;
                    r = data_t'(n);
                end
                {7'h30, 3'd1, 5'd2}: begin
                    for (int i = 0; i < 32; i++) n += a[i];
                    r = data_t'(n);
                end
                {7'h30, 3'd1, 5'd4}: r = {{24{a[7]}}, a[7:0]};
                {7'h30, 3'd1, 5'd5}: r = {{16{a[15]}}, a[15:0]};
                {7'h14, 3'd5, 5'd7}: begin
                    for (int i = 0; i < 4; i++) r[8*i +: 8] = (a[8*i +: 8] != 0) ? 8'hff : 8'h00;
                end
                {7'h34, 3'd5, 5'd24}: r = {a[7:0], a[15:8], a[23:16], a[31:24]};
                default:              bad = 1'b1;
            endcase
        end else begin
            bad = 1'b1;
        end
        // Unknown encodings return zero
        if (bad) r = '0;
        return {bad, r};
    endfunction

    // ----------------------------------------------------------------------
    // Sampling at the falling edge sees every handshake signal settled
    // ----------------------------------------------------------------------
    always @(negedge clk_i) begin
        cycle_count++;
        if (!rst_i) begin
            // Nothing may come out and the stage must be open before the first input
            if (!seen_input && out_valid_i) begin
                $display("out_valid_o went high before any operation was accepted");
                protocol_errors_o++;
            end
            if (!seen_input && !in_ready_i) begin
                $display("in_ready_o was low before any operation was accepted");
                protocol_errors_o++;
            end
            if (streaming_i && !in_ready_i) begin
                $display("in_ready_o dropped while streaming with out_ready_i held high");
                protocol_errors_o++;
            end

            // Output side, compare against the oldest outstanding operation
            if (out_valid_i && out_ready_i) begin
                if (exp_data.size() == 0) begin
                    $display("A result left the DUT with no operation outstanding");
                    protocol_errors_o++;
                end else begin
                    head_data    = exp_data.pop_front();
                    head_illegal = exp_illegal.pop_front();
                    head_instr   = exp_instr.pop_front();
                    head_cycle   = exp_cycle.pop_front();
                    head_timed   = exp_timed.pop_front();
                    if (result_i !== head_data) begin
                        $display("Fail: result_o expected %08h actual %08h for instr %08h",
                                 head_data, result_i, head_instr);
                        value_errors_o++;
                    end
                    if (illegal_i !== head_illegal) begin
                        $display("Fail: illegal_o expected %0h actual %0h for instr %08h",
                                 head_illegal, illegal_i, head_instr);
                        value_errors_o++;
                    end
                    if (head_timed && (cycle_count - head_cycle != STREAM_LATENCY)) begin
                        $display("Result for instr %08h took %0d cycles instead of %0d",
                                 head_instr, cycle_count - head_cycle, STREAM_LATENCY);
                        protocol_errors_o++;
                    end
                end
            end

            // Input side, queue the reference result in acceptance order
            if (in_valid_i && in_ready_i) begin
                expected = reference_result(instr_i, operand_a_i, operand_b_i);
                exp_data.push_back(expected[31:0]);
                exp_illegal.push_back(expected[32]);
                exp_instr.push_back(instr_i);
                exp_cycle.push_back(cycle_count);
                exp_timed.push_back(streaming_i);
                seen_input = 1'b1;
            end
            pending_o = exp_data.size();
        end
    end

endmodule

// ==== tests/tb_bmu_top.sv ====
`timescale 1ns/1ps

module tb_bmu_top import bmu_pkg::*; ();

    localparam time CLK_PERIOD     = 100;
    localparam time DRIVE_DELAY    = 5;
    localparam int  NUM_OPS        = 400;
    localparam int  STREAM_OPS     = 40;
    localparam int  TIMEOUT_CYCLES = NUM_OPS * 6 + 100;

    logic   clk_i;
    logic   rst_i;
    logic   in_valid_i;
    logic   in_ready_o;
    instr_t instr_i;
    data_t  operand_a_i;
    data_t  operand_b_i;
    logic   out_valid_o;
    logic   out_ready_i;
    data_t  result_o;
    logic   illegal_o;

    integer seed;
    logic   hold_ready;
    logic   streaming;
    int     pending;
    int     value_errors;
    int     protocol_errors;
    int     cycles;

    bmu_top u_dut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .instr_i     (instr_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .result_o    (result_o),
        .illegal_o   (illegal_o)
    );

    bmu_checker u_checker (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .in_valid_i        (in_valid_i),
        .in_ready_i        (in_ready_o),
        .instr_i           (instr_i),
        .operand_a_i       (operand_a_i),
        .operand_b_i       (operand_b_i),
        .out_valid_i       (out_valid_o),
        .out_ready_i       (out_ready_i),
        .result_i          (result_o),
        .illegal_i         (illegal_o),
        .streaming_i       (streaming),
        .pending_o         (pending),
        .value_errors_o    (value_errors),
        .protocol_errors_o (protocol_errors)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Base encodings with rd, rs1 and rs2 at zero, in the order of bmu_opcode_e
    function automatic instr_t op_encoding(input int idx);
        case (idx)
            0:  return 32'h2000_2033;
            1:  return 32'h2000_4033;
            2:  return 32'h2000_6033;
            3:  return 32'h4000_7033;
            4:  return 32'h4000_6033;
            5:  return 32'h4000_4033;
            6:  return 32'h6000_1013;
            7:  return 32'h6010_1013;
            8:  return 32'h6020_1013;
            9:  return 32'h0a00_6033;
            10: return 32'h0a00_7033;
            11: return 32'h0a00_4033;
            12: return 32'h0a00_5033;
            13: return 32'h6040_1013;
            14: return 32'h6050_1013;
            15: return 32'h0800_4033;
            16: return 32'h6000_1033;
            17: return 32'h6000_5033;
            18: return 32'h2870_5013;
            19: return 32'h6980_5013;
            20: return 32'h4800_1033;
            21: return 32'h4800_5033;
            22: return 32'h6800_1033;
            default: return 32'h2800_1033;
        endcase
    endfunction

    // Forms whose rs2 field is part of the opcode
    function automatic logic op_is_unary(input int idx);
        case (idx)
            6, 7, 8, 13, 14, 15, 18, 19: return 1'b1;
            default:                     return 1'b0;
        endcase
    endfunction

    // Move to just after the next rising edge and redraw the consumer ready
    task automatic step();
        @(posedge clk_i);
        #(DRIVE_DELAY);
        if (!hold_ready) out_ready_i = ({$random(seed)} % 10) >= 3;
    endtask

    // Zero and edge values show up far more often than in plain random words
    task automatic pick_operand(output data_t value);
        int kind;
        kind = {$random(seed)} % 8;
        case (kind)
            0:       value = '0;
            1:       value = '1;
            2:       value = 32'h8000_0000;
            3:       value = 32'h7fff_ffff;
            4:       value = data_t'(1) << ({$random(seed)} % 32);
            5:       value = $random(seed) & 32'h00ff_0f00;
            default: value = $random(seed);
        endcase
    endtask

    task automatic pick_instr(output instr_t instr);
        int     idx;
        instr_t fields;
        if ({$random(seed)} % 10 == 0) begin
            instr = $random(seed);
        end else begin
            idx    = {$random(seed)} % 24;
            fields = $random(seed);
            // rd and rs1 are free everywhere, rs2 only in two-operand forms
            instr  = op_encoding(idx) | (fields & 32'h000f_8f80);
            if (!op_is_unary(idx)) instr = instr | (fields & 32'h01f0_0000);
        end
    endtask

    // Offer one operation and hold it until the DUT takes it
    task automatic send_op();
        instr_t instr;
        data_t  a;
        data_t  b;
        pick_instr(instr);
        pick_operand(a);
        pick_operand(b);
        in_valid_i  = 1'b1;
        instr_i     = instr;
        operand_a_i = a;
        operand_b_i = b;
        while (!in_ready_o) step();
        step();
        in_valid_i = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin
        seed        = 16314;
        rst_i       = 1'b1;
        in_valid_i  = 1'b0;
        instr_i     = '0;
        operand_a_i = '0;
        operand_b_i = '0;
        out_ready_i = 1'b0;
        hold_ready  = 1'b0;
        streaming   = 1'b0;
        repeat (4) @(posedge clk_i);
        #(DRIVE_DELAY);
        rst_i = 1'b0;

        // A few idle cycles so the post-reset state can be observed
        repeat (3) step();

        // Continuous input with the consumer always ready
        hold_ready  = 1'b1;
        out_ready_i = 1'b1;
        streaming   = 1'b1;
        repeat (STREAM_OPS) send_op();
        while (pending != 0) step();
        streaming  = 1'b0;
        hold_ready = 1'b0;

        // Random gaps on the input and random back-pressure on the output
        repeat (NUM_OPS - STREAM_OPS) begin
            while ({$random(seed)} % 4 == 0) step();
            send_op();
        end

        // Drain, then idle a little so a duplicated result would be seen
        hold_ready  = 1'b1;
        out_ready_i = 1'b1;
        while (pending != 0) step();
        repeat (4) step();

        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Cycle limit in case a handshake never completes
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d results still outstanding",
                 cycles, pending);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+common
common/bmu_pkg.sv
common/bmu_op_if.sv
bit_manip/count_zeros.sv
bit_manip/bit_manip_unit.sv
hw/bmu_decoder.sv
hw/bmu_result_buffer.sv
hw/bmu_top.sv
tests/bmu_checker.sv
tests/tb_bmu_top.sv

// ==== Bender.yml ====
package:
  name: bmu

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/bmu_pkg.sv
      - common/bmu_op_if.sv
      - bit_manip/count_zeros.sv
      - bit_manip/bit_manip_unit.sv
      - hw/bmu_decoder.sv
      - hw/bmu_result_buffer.sv
      - hw/bmu_top.sv
  - target: test
    files:
      - tests/bmu_checker.sv
      - tests/tb_bmu_top.sv
